//--- design/axil_read_arbiter.sv
`timescale 1ns/1ps
/* round-robin arbiter, fetch and load share one AXI4-Lite read bus
   one transaction on the bus at a time, the grant lasts until the owner's
   R handshake; the AR payload toward memory is registered, so m_arvalid
   rises the cycle after the requester's AR handshake */
module axil_read_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    // fetch requester
    input  logic                   f_ar_valid,
    input  rv32i_types::axil_ar_t  f_ar,
    output logic                   f_ar_ready,
    output logic                   f_r_valid,
    output rv32i_types::axil_r_t   f_r,
    input  logic                   f_r_ready,
    // load requester
    input  logic                   l_ar_valid,
    input  rv32i_types::axil_ar_t  l_ar,
    output logic                   l_ar_ready,
    output logic                   l_r_valid,
    output rv32i_types::axil_r_t   l_r,
    input  logic                   l_r_ready,
    // memory side
    output logic                   m_arvalid,
    output rv32i_types::axil_ar_t  m_ar,
    input  logic                   m_arready,
    input  logic                   m_rvalid,
    input  rv32i_types::axil_r_t   m_r,
    output logic                   m_rready
);
    import rv32i_types::*;

    logic busy;       // AR or R phase in progress
    logic owner_ld;   // current owner while busy, last served otherwise
    logic grant;
    logic pick_ld;
    logic r_fire;

    ////////////////////////////////////////////////////////////
    // request side
    ////////////////////////////////////////////////////////////
    // load wins if alone, or if fetch was served last
    assign pick_ld    = l_ar_valid && (!f_ar_valid || !owner_ld);
    assign grant      = !busy && (f_ar_valid || l_ar_valid);
    assign f_ar_ready = grant && !pick_ld;
    assign l_ar_ready = grant && pick_ld;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            owner_ld  <= 1'b1;   // fetch goes first on a tie after reset
            m_arvalid <= 1'b0;
        end else if (grant) begin
            busy      <= 1'b1;
            owner_ld  <= pick_ld;
            m_arvalid <= 1'b1;
        end else begin
            if (m_arvalid && m_arready) begin
                m_arvalid <= 1'b0;
            end
            if (r_fire) begin
                busy <= 1'b0;   // bus free next cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            m_ar <= pick_ld ? l_ar : f_ar;
        end
    end

    ////////////////////////////////////////////////////////////
    // response side
    ////////////////////////////////////////////////////////////
    assign m_rready  = busy && (owner_ld ? l_r_ready : f_r_ready);
    assign r_fire    = m_rvalid && m_rready;
    assign f_r_valid = busy && !owner_ld && m_rvalid;
    assign l_r_valid = busy && owner_ld && m_rvalid;
    assign f_r       = m_r;
    assign l_r       = m_r;

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ps
/* RV32I decode of the queue head into a registered valid/ready output
   fmt comes from the opcode alone; unknown opcodes give FMT_BAD with imm zero
   register fields are passed raw whatever the format */
module decode_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  rv32i_types::iq_entry_t   head_entry,
    input  logic                     empty,
    output logic                     pop,
    output logic                     dec_valid,
    output rv32i_types::dec_instr_t  dec,
    input  logic                     dec_ready
);
    import rv32i_types::*;

    instr_u      iw;
    instr_fmt_e  fmt;
    logic [31:0] imm;
    dec_instr_t  dec_d;

    assign iw = head_entry.instr;

    always_comb begin
        case (iw.r_fmt.opcode)
            OP_REG:                                 fmt = FMT_R;
            OP_IMM, OP_LOAD, OP_JALR,
            OP_FENCE, OP_SYSTEM:                    fmt = FMT_I;
            OP_STORE:                               fmt = FMT_S;
            OP_BRANCH:                              fmt = FMT_B;
            OP_LUI, OP_AUIPC:                       fmt = FMT_U;
            OP_JAL:                                 fmt = FMT_J;
            default:                                fmt = FMT_BAD;
        endcase
    end

    always_comb begin
        case (fmt)
            FMT_I:   imm = {{20{iw.i_fmt.imm_11_0[11]}}, iw.i_fmt.imm_11_0};
            FMT_S:   imm = {{20{iw.s_fmt.imm_11_5[6]}}, iw.s_fmt.imm_11_5, iw.s_fmt.imm_4_0};
            FMT_B:   imm = {{19{iw.b_fmt.imm_12}}, iw.b_fmt.imm_12, iw.b_fmt.imm_11,
                            iw.b_fmt.imm_10_5, iw.b_fmt.imm_4_1, 1'b0};
            FMT_U:   imm = {iw.u_fmt.imm_31_12, 12'b0};
            FMT_J:   imm = {{11{iw.j_fmt.imm_20}}, iw.j_fmt.imm_20, iw.j_fmt.imm_19_12,
                            iw.j_fmt.imm_11, iw.j_fmt.imm_10_1, 1'b0};
            default: imm = '0;   // R and bad
        endcase
    end

    assign dec_d = '{pc: head_entry.pc, opcode: iw.r_fmt.opcode, fmt: fmt,
                     rd: iw.r_fmt.rd, rs1: iw.r_fmt.rs1, rs2: iw.r_fmt.rs2,
                     funct3: iw.r_fmt.funct3, funct7: iw.r_fmt.funct7, imm: imm};

    // refill when the output slot is empty or leaving this cycle
    assign pop = !flush && !empty && (!dec_valid || dec_ready);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            dec_valid <= 1'b0;
        end else if (pop) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            dec <= dec_d;   // held under back-pressure
        end
    end

endmodule

//--- design/fetch_unit.sv
`timescale 1ns/1ps
/* sequential instruction fetch over an AXI4-Lite read port
   one request at a time, issued only while the queue has room for its word
   a redirect cannot withdraw a posted request; its response is taken off the
   bus and dropped instead */
module fetch_unit (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              redirect,
    input  logic [31:0]                       redirect_pc,
    output logic                              ar_valid,
    output rv32i_types::axil_ar_t             ar,
    input  logic                              ar_ready,
    input  logic                              r_valid,
    input  rv32i_types::axil_r_t              r,
    output logic                              r_ready,
    output logic                              push,
    output rv32i_types::iq_entry_t            push_entry,
    input  logic [rv32i_types::IQ_CNT_W-1:0]  iq_count
);
    import rv32i_types::*;

    logic [31:0] fetch_pc;    // next address to request
    logic [31:0] req_pc;      // address of the request in flight
    logic        r_wait;      // AR done, waiting on R
    logic        drop;        // response in flight is stale
    logic        in_flight;
    logic        r_fire;
    logic        has_room;
    logic        issue;

    assign in_flight = ar_valid || r_wait;
    assign r_fire    = r_valid && r_ready;
    // a new request is only issued with nothing in flight, its word must still fit
    assign has_room  = iq_count < IQ_CNT_W'(IQ_DEPTH);
    assign issue     = !in_flight && has_room && !redirect;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc <= RESET_PC;
            ar_valid <= 1'b0;
            r_wait   <= 1'b0;
            drop     <= 1'b0;
        end else begin
            if (ar_valid && ar_ready) begin
                ar_valid <= 1'b0;
                r_wait   <= 1'b1;
            end else if (issue) begin
                ar_valid <= 1'b1;
                fetch_pc <= fetch_pc + 32'd4;
            end
            if (r_fire) begin
                r_wait <= 1'b0;
            end
            if (redirect) begin
                fetch_pc <= redirect_pc;           // overrides the +4 above
            end
            if (redirect && in_flight && !r_fire) begin
                drop <= 1'b1;
            end else if (r_fire) begin
                drop <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_pc <= fetch_pc;   // held stable while ar_valid is up
        end
    end

    assign ar         = '{addr: req_pc, prot: AXI_PROT_INSTR};
    assign r_ready    = r_wait;
    assign push       = r_fire && !drop;          // same-cycle flush wins in the queue
    assign push_entry = '{pc: req_pc, instr: r.data};

endmodule

//--- design/frontend_top.sv
`timescale 1ns/1ps
/* RV32I instruction front end: fetch, instruction queue, decode
   fetch and the external load port share one AXI4-Lite read bus (AR and R only)
   redirect is a single-cycle pulse; it flushes the queue and the decode output */
module frontend_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     redirect,
    input  logic [31:0]              redirect_pc,
    // memory master
    output logic                     m_arvalid,
    output rv32i_types::axil_ar_t    m_ar,
    input  logic                     m_arready,
    input  logic                     m_rvalid,
    input  rv32i_types::axil_r_t     m_r,
    output logic                     m_rready,
    // load port
    input  logic                     ld_arvalid,
    input  logic [31:0]              ld_addr,
    output logic                     ld_arready,
    output logic                     ld_rvalid,
    output logic [31:0]              ld_rdata,
    input  logic                     ld_rready,
    // decoded output
    output logic                     dec_valid,
    output rv32i_types::dec_instr_t  dec,
    input  logic                     dec_ready
);
    import rv32i_types::*;

    logic                f_ar_valid;
    axil_ar_t            f_ar;
    logic                f_ar_ready;
    logic                f_r_valid;
    axil_r_t             f_r;
    logic                f_r_ready;
    axil_ar_t            l_ar;
    axil_r_t             l_r;
    logic                iq_push;
    logic                iq_pop;
    logic                iq_empty;
    iq_entry_t           iq_push_entry;
    iq_entry_t           iq_head;
    logic [IQ_CNT_W-1:0] iq_count;

    assign l_ar     = '{addr: ld_addr, prot: AXI_PROT_DATA};
    assign ld_rdata = l_r.data;

    fetch_unit u_fetch (
        .clk(clk), .rst(rst),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .ar_valid(f_ar_valid), .ar(f_ar), .ar_ready(f_ar_ready),
        .r_valid(f_r_valid), .r(f_r), .r_ready(f_r_ready),
        .push(iq_push), .push_entry(iq_push_entry), .iq_count(iq_count)
    );

    instr_queue u_iq (
        .clk(clk), .rst(rst),
        .push(iq_push), .pop(iq_pop), .flush(redirect),
        .push_entry(iq_push_entry), .head_entry(iq_head),
        .full(), .empty(iq_empty), .count(iq_count)
    );

    decode_stage u_dec (
        .clk(clk), .rst(rst), .flush(redirect),
        .head_entry(iq_head), .empty(iq_empty), .pop(iq_pop),
        .dec_valid(dec_valid), .dec(dec), .dec_ready(dec_ready)
    );

    axil_read_arbiter u_arb (
        .clk(clk), .rst(rst),
        .f_ar_valid(f_ar_valid), .f_ar(f_ar), .f_ar_ready(f_ar_ready),
        .f_r_valid(f_r_valid), .f_r(f_r), .f_r_ready(f_r_ready),
        .l_ar_valid(ld_arvalid), .l_ar(l_ar), .l_ar_ready(ld_arready),
        .l_r_valid(ld_rvalid), .l_r(l_r), .l_r_ready(ld_rready),
        .m_arvalid(m_arvalid), .m_ar(m_ar), .m_arready(m_arready),
        .m_rvalid(m_rvalid), .m_r(m_r), .m_rready(m_rready)
    );

endmodule

//--- design/instr_queue.sv
`timescale 1ns/1ps
/* circular queue of fetched instructions, IQ_DEPTH entries
   a push shows up at the head one cycle later, pop is combinational on head_entry
   flush wins over push and pop; a push while full is lost unless a pop
   frees a slot in the same cycle */
module instr_queue (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               push,
    input  logic                               pop,
    input  logic                               flush,
    input  rv32i_types::iq_entry_t             push_entry,
    output rv32i_types::iq_entry_t             head_entry,
    output logic                               full,
    output logic                               empty,
    output logic [rv32i_types::IQ_CNT_W-1:0]   count
);
    import rv32i_types::*;

    iq_entry_t           mem [IQ_DEPTH];
    logic [IQ_PTR_W-1:0] head;
    logic [IQ_PTR_W-1:0] tail;
    logic [IQ_CNT_W-1:0] occ;
    logic                push_ok;
    logic                pop_ok;

    assign pop_ok  = pop && !empty;
    assign push_ok = push && (!full || pop_ok);   // full slot reused by same-cycle pop

    ////////////////////////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head <= '0;
            tail <= '0;
            occ  <= '0;
        end else begin
            if (push_ok) begin
                tail <= tail + 1'b1;   // wraps, depth is a power of two
            end
            if (pop_ok) begin
                head <= head + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   occ <= occ + 1'b1;
                2'b01:   occ <= occ - 1'b1;
                default: occ <= occ;       // none or both
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (push_ok && !flush) begin
            mem[tail] <= push_entry;
        end
    end

    assign head_entry = mem[head];
    assign count      = occ;
    assign full       = (occ == IQ_CNT_W'(IQ_DEPTH));
    assign empty      = (occ == '0);

endmodule

//--- design/rv32i_types.sv
/* shared types for the RV32I instruction front end
   IQ_DEPTH must be a power of two of 2 or more
   only the AXI4-Lite read channels are modelled, RRESP is carried but ignored */
package rv32i_types;

    ////////////////////////////////////////////////////////////
    // sizes and constants
    ////////////////////////////////////////////////////////////
    localparam int          IQ_DEPTH = 8;
    localparam int          IQ_PTR_W = $clog2(IQ_DEPTH);
    localparam int          IQ_CNT_W = $clog2(IQ_DEPTH) + 1;   // holds 0..IQ_DEPTH
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    localparam logic [2:0] AXI_PROT_INSTR = 3'b100;   // instruction access
    localparam logic [2:0] AXI_PROT_DATA  = 3'b000;   // data access, load port

    // base opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_FENCE  = 7'b0001111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    ////////////////////////////////////////////////////////////
    // instruction queue entry and format views
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } iq_entry_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one fetched word, read in the layout its opcode selects
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_BAD
    } instr_fmt_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [6:0]  opcode;
        instr_fmt_e  fmt;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [31:0] imm;      // sign extended
    } dec_instr_t;

    ////////////////////////////////////////////////////////////
    // AXI4-Lite read channel payloads
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  prot;
    } axil_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } axil_r_t;

endpackage

//--- sim.f
design/rv32i_types.sv
design/instr_queue.sv
design/fetch_unit.sv
design/axil_read_arbiter.sv
design/decode_stage.sv
design/frontend_top.sv
testbench/tb_axil_mem.sv
testbench/tb_frontend.sv

//--- testbench/tb_axil_mem.sv
`timescale 1ns/1ps
/* read-only AXI4-Lite memory model, 1024 words, address bits 11:2 pick the word
   words is filled by the testbench at time zero, higher addresses alias
   one transaction at a time, R follows AR after 0 to 5 extra cycles, RRESP is OKAY */
module tb_axil_mem (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   arvalid,
    input  rv32i_types::axil_ar_t  ar,
    output logic                   arready,
    output logic                   rvalid,
    output rv32i_types::axil_r_t   r,
    input  logic                   rready
);
    logic [31:0] words [1024];
    logic        busy;         // AR taken, R not done yet
    int          delay;
    integer      seed = 16;

    always @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            busy    <= 1'b0;
            delay   <= 0;
        end else if (!busy) begin
            if (arvalid && arready) begin
                busy    <= 1'b1;
                arready <= 1'b0;
                r       <= '{data: words[ar.addr[11:2]], resp: 2'b00};
                delay   <= $unsigned($random(seed)) % 6;
            end else begin
                arready <= ($random(seed) & 1) != 0;   // random AR stalls
            end
        end else if (!rvalid) begin
            if (delay == 0) begin
                rvalid <= 1'b1;
            end else begin
                delay <= delay - 1;
            end
        end else if (rready) begin
            rvalid <= 1'b0;
            busy   <= 1'b0;
        end
    end

endmodule

//--- testbench/tb_frontend.sv
`timescale 1ns/1ps
/* testbench for the RV32I front end, memory image is 4 KB and aliases above that
   the in-flight bound is checked only up to the first redirect, since dropped
   responses are invisible from outside; the run stops at the first error */
module tb_frontend;
    import rv32i_types::*;

    logic        clk;
    logic        rst;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        m_arvalid;
    axil_ar_t    m_ar;
    logic        m_arready;
    logic        m_rvalid;
    axil_r_t     m_r;
    logic        m_rready;
    logic        ld_arvalid;
    logic [31:0] ld_addr;
    logic        ld_arready;
    logic        ld_rvalid;
    logic [31:0] ld_rdata;
    logic        ld_rready;
    logic        dec_valid;
    dec_instr_t  dec;
    logic        dec_ready;

    logic [31:0] image [1024];   // same words as the memory model
    integer      seed;
    logic [31:0] exp_pc;
    int          accepted;
    int          unaccepted;     // fetch AR handshakes minus accepted decodes
    logic        bound_armed;
    logic        ar_stall;
    logic        r_stall;
    logic        dec_stall;
    axil_ar_t    ar_seen;
    logic [31:0] rdata_seen;
    dec_instr_t  dec_seen;

    frontend_top dut (
        .clk(clk), .rst(rst), .redirect(redirect), .redirect_pc(redirect_pc),
        .m_arvalid(m_arvalid), .m_ar(m_ar), .m_arready(m_arready),
        .m_rvalid(m_rvalid), .m_r(m_r), .m_rready(m_rready),
        .ld_arvalid(ld_arvalid), .ld_addr(ld_addr), .ld_arready(ld_arready),
        .ld_rvalid(ld_rvalid), .ld_rdata(ld_rdata), .ld_rready(ld_rready),
        .dec_valid(dec_valid), .dec(dec), .dec_ready(dec_ready)
    );

    tb_axil_mem u_mem (
        .clk(clk), .rst(rst), .arvalid(m_arvalid), .ar(m_ar), .arready(m_arready),
        .rvalid(m_rvalid), .r(m_r), .rready(m_rready)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // reference decode
    ////////////////////////////////////////////////////////////
    function automatic instr_fmt_e ref_fmt(input logic [31:0] w);
        case (w[6:0])
            7'h33:                             return FMT_R;
            7'h13, 7'h03, 7'h67, 7'h0f, 7'h73: return FMT_I;
            7'h23:                             return FMT_S;
            7'h63:                             return FMT_B;
            7'h37, 7'h17:                      return FMT_U;
            7'h6f:                             return FMT_J;
            default:                           return FMT_BAD;
        endcase
    endfunction

    function automatic logic [31:0] ref_imm(input logic [31:0] w);
        case (ref_fmt(w))
            FMT_I:   return {{20{w[31]}}, w[31:20]};
            FMT_S:   return {{20{w[31]}}, w[31:25], w[11:7]};
            FMT_B:   return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            FMT_U:   return {w[31:12], 12'b0};
            FMT_J:   return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] fixed_word(input int k);
        case (k)
            0:       return 32'h002081b3;   // R
            1:       return 32'h407302b3;   // R, funct7 set
            2:       return 32'hfff00093;   // I, negative
            3:       return 32'h00812203;   // I, load
            4:       return 32'h000280e7;   // I, jalr
            5:       return 32'hfe20ae23;   // S, negative
            6:       return 32'h00112423;   // S
            7:       return 32'hfe208ce3;   // B, backward
            8:       return 32'h00209463;   // B, forward
            9:       return 32'h123452b7;   // U
            10:      return 32'hfffff517;   // U, auipc
            11:      return 32'hff1ff0ef;   // J, backward
            12:      return 32'h0010006f;   // J, forward
            13:      return 32'h00000073;   // I, system
            14:      return 32'h0ff0000f;   // I, fence
            default: return 32'hffffffff;   // no valid opcode
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // checking helpers
    ////////////////////////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic expect_eq(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        assert (got === exp)
            else abort_run($sformatf("MISMATCH %s got %0h expected %0h", name, got, exp));
    endtask

    task automatic check_decode(input dec_instr_t got, input logic [31:0] pc);
        logic [31:0] word;
        word = image[pc[11:2]];
        expect_eq("dec.pc", got.pc, pc);
        expect_eq("dec.opcode", got.opcode, word[6:0]);
        expect_eq("dec.rd", got.rd, word[11:7]);
        expect_eq("dec.funct3", got.funct3, word[14:12]);
        expect_eq("dec.rs1", got.rs1, word[19:15]);
        expect_eq("dec.rs2", got.rs2, word[24:20]);
        expect_eq("dec.funct7", got.funct7, word[31:25]);
        expect_eq("dec.fmt", got.fmt, ref_fmt(word));
        expect_eq("dec.imm", got.imm, ref_imm(word));
    endtask

    ////////////////////////////////////////////////////////////
    // monitor, sampled at the rising edge before any update
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rst) begin
            exp_pc      <= RESET_PC;
            accepted    <= 0;
            unaccepted  <= 0;
            bound_armed <= 1'b1;
            ar_stall    <= 1'b0;
            r_stall     <= 1'b0;
            dec_stall   <= 1'b0;
        end else begin
            if (ar_stall) begin
                assert (m_arvalid) else abort_run("m_arvalid withdrawn before its handshake");
                expect_eq("m_ar", m_ar, ar_seen);
            end
            if (r_stall) begin
                assert (ld_rvalid) else abort_run("ld_rvalid withdrawn before its handshake");
                expect_eq("ld_rdata", ld_rdata, rdata_seen);
            end
            if (dec_stall) begin
                assert (dec_valid) else abort_run("dec_valid dropped while dec_ready was low");
                expect_eq("dec", dec, dec_seen);
            end
            if (dec_valid && dec_ready) begin
                check_decode(dec, exp_pc);
                accepted <= accepted + 1;
            end
            if (bound_armed) begin
                assert (unaccepted <= IQ_DEPTH + 2)
                    else abort_run($sformatf("%0d fetched words pending, more than allowed",
                                             unaccepted));
            end

            if (redirect) begin
                exp_pc      <= redirect_pc;
                bound_armed <= 1'b0;
            end else if (dec_valid && dec_ready) begin
                exp_pc <= exp_pc + 32'd4;
            end
            unaccepted <= unaccepted
                          + int'(m_arvalid && m_arready && m_ar.prot == AXI_PROT_INSTR)
                          - int'(dec_valid && dec_ready);
            ar_stall   <= m_arvalid && !m_arready;
            ar_seen    <= m_ar;
            r_stall    <= ld_rvalid && !ld_rready;
            rdata_seen <= ld_rdata;
            dec_stall  <= dec_valid && !dec_ready && !redirect;   // redirect clears dec
            dec_seen   <= dec;
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus tasks, all entered and left at a rising edge
    ////////////////////////////////////////////////////////////
    task automatic fill_memory();
        for (int i = 0; i < 1024; i++) begin
            if (i % 32 < 16) begin
                image[i] = fixed_word(i % 16);
            end else begin
                image[i] = $random(seed);
            end
            u_mem.words[i] = image[i];
        end
    endtask

    task automatic run_decodes(input int n);
        int goal;
        int waited;
        goal   = accepted + n;
        waited = 0;
        while (accepted < goal) begin
            @(posedge clk);
            waited++;
            if (waited > 100 * n) begin
                abort_run("decoded instructions stopped arriving");
            end
        end
    endtask

    task automatic send_redirect(input logic [31:0] target);
        redirect    <= 1'b1;
        redirect_pc <= target;
        @(posedge clk);
        redirect    <= 1'b0;
    endtask

    task automatic wait_fetch_on_bus();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > 200) begin
                abort_run("no fetch request showed up on the memory bus");
            end
        end while (!(m_arvalid && m_ar.prot == AXI_PROT_INSTR));
    endtask

    task automatic do_load(input logic [31:0] addr);
        int waited;
        int hold;
        ld_addr    <= addr;
        ld_arvalid <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > 200) begin
                abort_run("load request never granted, load port starved");
            end
        end while (!ld_arready);
        ld_arvalid <= 1'b0;
        hold = 4 + $unsigned($random(seed)) % 8;
        repeat (hold) @(posedge clk);   // R mostly arrives while ld_rready is low
        ld_rready <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > 200) begin
                abort_run("load response never arrived");
            end
        end while (!ld_rvalid);
        expect_eq("ld_rdata", ld_rdata, image[addr[11:2]]);
        ld_rready <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        rst         = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        ld_arvalid  = 1'b0;
        ld_addr     = '0;
        ld_rready   = 1'b0;
        dec_ready   = 1'b0;
        seed        = 16;
        fill_memory();
        repeat (16) @(posedge clk);
        expect_eq("m_arvalid", m_arvalid, 1'b0);     // idle out of reset
        expect_eq("m_rready", m_rready, 1'b0);
        expect_eq("ld_arready", ld_arready, 1'b0);
        expect_eq("ld_rvalid", ld_rvalid, 1'b0);
        expect_eq("dec_valid", dec_valid, 1'b0);
        rst       <= 1'b0;
        dec_ready <= 1'b1;

        run_decodes(40);                 // straight-line fetch, all formats

        dec_ready <= 1'b0;               // back-pressure, queue fills
        repeat (40) @(posedge clk);
        dec_ready <= 1'b1;
        run_decodes(24);

        repeat (8) begin                 // loads between fetches
            do_load($random(seed) & 32'h0000_0ffc);
            run_decodes(1);
        end

        repeat (4) begin
            send_redirect($random(seed) & 32'h0000_0ffc);
            run_decodes(12);
        end

        repeat (4) begin                 // response of this fetch must be dropped
            wait_fetch_on_bus();
            send_redirect($random(seed) & 32'h0000_0ffc);
            run_decodes(8);
        end

        repeat (4) begin
            do_load($random(seed) & 32'h0000_0ffc);
            run_decodes(2);
        end

        $display("sim passed");
        $finish;
    end

endmodule
